// ==== bench/rename_chk.sv ====
`default_nettype none

module rename_chk #(
   parameter int  AREGS = rename_pkg::DEF_AREGS,
   parameter int  PREGS = rename_pkg::DEF_PREGS,
   localparam int CNT_W = $clog2(PREGS - AREGS + 1)
) (
   input logic                    clka,
   input logic                    reset,
   input rename_pkg::rename_op_t  op,
   input logic                    ready,
   input logic                    done,
   input logic                    fault,
   input logic [CNT_W-1:0]        free_count,
   input rename_pkg::ctrl_state_t ctrl_state
);
   timeunit 1ns;
   timeprecision 100ps;
   import rename_pkg::*;

   // =========================================================================
   // Handshake rules on the top-level ports
   // =========================================================================
   a_fault_done : assert property (@(posedge clka) disable iff (reset) fault |-> done)
      else $error("fault seen without done");

   // Every real op is answered on the next edge, and nothing else is
   a_done_op : assert property (@(posedge clka) disable iff (reset)
      (op != OP_NONE) |=> done)
      else $error("done missing one cycle after an op");
   a_done_idle : assert property (@(posedge clka) disable iff (reset)
      (op == OP_NONE) |=> !done)
      else $error("done raised after an idle cycle");

   // The free list never holds more than the registers outside the map
   a_count_max : assert property (@(posedge clka) disable iff (reset)
      free_count <= CNT_W'(PREGS - AREGS))
      else $error("free_count above the free list depth");

   a_ready_stays : assert property (@(posedge clka) disable iff (reset) ready |=> ready)
      else $error("ready fell after init");   // Init runs once per reset

   // An op that arrives while the free list is still filling is rejected
   a_init_fault : assert property (@(posedge clka) disable iff (reset)
      ((ctrl_state == ST_INIT) && (op != OP_NONE)) |=> fault)
      else $error("op presented during init was not rejected");

endmodule

// Attached inside every rename_unit with the state taken straight from the controller
bind rename_unit rename_chk #(
   .AREGS (AREGS),
   .PREGS (PREGS)
) u_chk (
   .clka       (clka),
   .reset      (reset),
   .op         (op),
   .ready      (ready),
   .done       (done),
   .fault      (fault),
   .free_count (free_count),
   .ctrl_state (u_ctrl.state)
);

`default_nettype wire

// ==== bench/rename_tb.sv ====
`default_nettype none

module rename_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import rename_pkg::*;

   localparam int AREGS   = DEF_AREGS;
   localparam int PREGS   = DEF_PREGS;
   localparam int NCHECK  = DEF_NCHECK;
   localparam int DEPTH   = PREGS - AREGS;     // Free list entries
   localparam int AR_W    = $clog2(AREGS);
   localparam int PRN_W   = $clog2(PREGS);
   localparam int CK_W    = $clog2(NCHECK);
   localparam int CNT_W   = $clog2(DEPTH + 1);
   localparam int PERIOD  = 4;
   localparam int RST_CYC = 5;
   // Worst case op counts of the five tests
   localparam int OPS_ALL  = 3 + 12 + 11 + 56 + 28;
   localparam int LIMIT_NS = (RST_CYC + DEPTH + OPS_ALL) * PERIOD * 2 + 200;

   logic             clka;
   logic             reset;
   rename_op_t       op;
   logic [AR_W-1:0]  areg_dst;
   logic [AR_W-1:0]  areg_src_a;
   logic [AR_W-1:0]  areg_src_b;
   logic [CK_W-1:0]  chk_sel;
   logic [PRN_W-1:0] free_preg;
   logic             ready;
   logic             done;
   logic             fault;
   logic [PRN_W-1:0] preg_src_a;
   logic [PRN_W-1:0] preg_src_b;
   logic [PRN_W-1:0] preg_dst;
   logic [PRN_W-1:0] preg_old;
   logic [CK_W-1:0]  chk_id;
   logic [CNT_W-1:0] free_count;

   // Reference model: map, free list as an ever growing sequence, ring counters
   int model_map [AREGS];
   int fl_seq [512];                            // Every entry ever written, in order
   int fl_rd;
   int fl_wr;
   int ck_head;                                 // Counters never wrap, slot is modulo NCHECK
   int ck_tail;
   int saved_map [NCHECK][AREGS];
   int saved_rd [NCHECK];

   logic [31:0] lfsr = 32'hf53f_9504;
   string cur_test;
   int    errors;
   int    ops;
   int    tests_run;
   int    err0;
   int    ops0;
   bit    last_fault;
   int    last_dst;
   int    last_chk_id;

   tb_clock #(.PERIOD_NS(PERIOD), .RESET_CYCLES(RST_CYC)) u_clock (
      .clka  (clka),
      .reset (reset)
   );

   rename_unit #(.AREGS(AREGS), .PREGS(PREGS), .NCHECK(NCHECK)) dut (
      .clka       (clka),
      .reset      (reset),
      .op         (op),
      .areg_dst   (areg_dst),
      .areg_src_a (areg_src_a),
      .areg_src_b (areg_src_b),
      .chk_sel    (chk_sel),
      .free_preg  (free_preg),
      .ready      (ready),
      .done       (done),
      .fault      (fault),
      .preg_src_a (preg_src_a),
      .preg_src_b (preg_src_b),
      .preg_dst   (preg_dst),
      .preg_old   (preg_old),
      .chk_id     (chk_id),
      .free_count (free_count)
   );

   // =========================================================================
   // Helpers
   // =========================================================================

   // Taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = (v << 1) | int'(lfsr[0]);      // New bit enters at the bottom
      end
      return v;
   endfunction

   task automatic check_value(input string what, input int exp, input int act);
      assert (exp == act) else begin
         $display("error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string msg);
      assert (cond) else begin
         $display("%s: %s", cur_test, msg);
         errors++;
      end
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      err0     = errors;
      ops0     = ops;
   endtask

   task automatic end_test();
      $display("%-20s %3d ops  %0d errors", cur_test, ops - ops0, errors - err0);
      tests_run++;
   endtask

   // Predicts the op from the model, presents it on a falling edge and checks
   // the answer one cycle later; starts and ends on a falling edge
   task automatic run_op(input rename_op_t o, input int dst, input int sa, input int sb,
                         input int sel, input int fpreg);
      bit exp_fault;
      int exp_dst;
      int exp_old;
      int exp_a;
      int exp_b;
      int exp_id;
      int live;
      int ofs;
      exp_fault = 1'b0;
      exp_dst   = 0;
      exp_old   = 0;
      exp_a     = 0;
      exp_b     = 0;
      exp_id    = 0;
      live      = ck_tail - ck_head;
      case (o)
         OP_RENAME: begin
            if (fl_wr == fl_rd) begin
               exp_fault = 1'b1;                // Nothing to allocate
            end else begin
               exp_dst = fl_seq[fl_rd];
               exp_old = model_map[dst];
               exp_a   = model_map[sa];        // Lookups see the map before the write
               exp_b   = model_map[sb];
               model_map[dst] = exp_dst;
               fl_rd++;
            end
         end
         OP_CHECKPOINT: begin
            if (live == NCHECK) begin
               exp_fault = 1'b1;
            end else begin
               exp_id = ck_tail % NCHECK;
               for (int i = 0; i < AREGS; i++)
                  saved_map[exp_id][i] = model_map[i];
               saved_rd[exp_id] = fl_rd;
               ck_tail++;
            end
         end
         OP_RESTORE: begin
            ofs = (sel - ck_head % NCHECK + NCHECK) % NCHECK;   // Age of the slot
            if (ofs >= live) begin
               exp_fault = 1'b1;
            end else begin
               for (int i = 0; i < AREGS; i++)
                  model_map[i] = saved_map[sel][i];
               fl_rd   = saved_rd[sel];
               ck_tail = ck_head + ofs + 1;    // Younger slots are dropped
            end
         end
         OP_COMMIT: begin
            if (live == 0)
               exp_fault = 1'b1;
            else
               ck_head++;
         end
         OP_FREE: begin
            if (fl_wr - fl_rd == DEPTH) begin
               exp_fault = 1'b1;
            end else begin
               fl_seq[fl_wr] = fpreg;
               fl_wr++;
            end
         end
         default: ;
      endcase
      op         = o;
      areg_dst   = dst[AR_W-1:0];
      areg_src_a = sa[AR_W-1:0];
      areg_src_b = sb[AR_W-1:0];
      chk_sel    = sel[CK_W-1:0];
      free_preg  = fpreg[PRN_W-1:0];
      @(negedge clka);
      op = OP_NONE;                             // A following call overrides this
      ops++;
      check_true(done === 1'b1, "done did not follow the op");
      check_value("fault", int'(exp_fault), int'(fault));
      check_value("free_count", fl_wr - fl_rd, int'(free_count));
      if (!exp_fault && o == OP_RENAME) begin
         check_value("preg_dst", exp_dst, int'(preg_dst));
         check_value("preg_old", exp_old, int'(preg_old));
         check_value("preg_src_a", exp_a, int'(preg_src_a));
         check_value("preg_src_b", exp_b, int'(preg_src_b));
      end
      if (!exp_fault && o == OP_CHECKPOINT)
         check_value("chk_id", exp_id, int'(chk_id));
      last_fault  = fault;
      last_dst    = int'(preg_dst);
      last_chk_id = int'(chk_id);
   endtask

   // =========================================================================
   // Tests
   // =========================================================================
   task automatic test_init();
      int cycles;
      begin_test("init");
      cycles = 0;
      while (ready !== 1'b1 && cycles < 4 * DEPTH) begin
         @(negedge clka);
         cycles++;
         if (cycles == 2) begin
            op = OP_RENAME;                     // Presented while the list is filling
         end else if (cycles == 3) begin
            check_true(done === 1'b1 && fault === 1'b1, "op during init was not rejected");
            op = OP_NONE;
         end
      end
      check_true(ready === 1'b1, "ready never rose after reset");
      check_value("cycles to ready", DEPTH, cycles);
      check_value("free_count after init", DEPTH, int'(free_count));
      run_op(OP_RENAME, 2, 3, 5, 0, 0);
      check_value("first allocation", AREGS, last_dst);
      check_value("identity source a", 3, int'(preg_src_a));
      check_value("identity source b", 5, int'(preg_src_b));
      run_op(OP_RENAME, 6, 6, 7, 0, 0);
      end_test();
   endtask

   task automatic test_random_renames();
      int d;
      int a;
      int b;
      begin_test("random_renames");
      for (int i = 0; i < 12; i++) begin
         d = rand_bits(AR_W);
         a = rand_bits(AR_W);
         b = rand_bits(AR_W);
         run_op(OP_RENAME, d, a, b, 0, 0);
      end
      end_test();
   endtask

   task automatic test_checkpoint_restore();
      int snap [AREGS];
      int id;
      int first_dst;
      int first_reg;
      begin_test("checkpoint_restore");
      for (int i = 0; i < AREGS; i++)
         snap[i] = model_map[i];               // Map as the branch sees it
      run_op(OP_CHECKPOINT, 0, 0, 0, 0, 0);
      id        = last_chk_id;
      first_reg = rand_bits(AR_W);
      run_op(OP_RENAME, first_reg, 0, 1, 0, 0);
      first_dst = last_dst;
      for (int i = 0; i < 3; i++)
         run_op(OP_RENAME, rand_bits(AR_W), rand_bits(AR_W), rand_bits(AR_W), 0, 0);
      run_op(OP_RESTORE, 0, 0, 0, id, 0);
      run_op(OP_RENAME, rand_bits(AR_W), first_reg, 7, 0, 0);
      check_value("restored source", snap[first_reg], int'(preg_src_a));
      check_value("reallocated register", first_dst, last_dst);
      for (int i = 0; i < 3; i++)
         run_op(OP_RENAME, rand_bits(AR_W), i, i + 4, 0, 0);
      run_op(OP_COMMIT, 0, 0, 0, 0, 0);         // Branch resolved, ring empty again
      end_test();
   endtask

   task automatic test_exhaust_free();
      int pa;
      int pb;
      int pc;
      begin_test("exhaust_free");
      while (fl_wr - fl_rd > 0)
         run_op(OP_RENAME, rand_bits(AR_W), rand_bits(AR_W), rand_bits(AR_W), 0, 0);
      run_op(OP_RENAME, 1, 2, 3, 0, 0);
      check_true(last_fault, "rename on an empty free list was accepted");
      pa = rand_bits(PRN_W);
      pb = rand_bits(PRN_W);
      pc = rand_bits(PRN_W);
      run_op(OP_FREE, 0, 0, 0, 0, pa);
      run_op(OP_FREE, 0, 0, 0, 0, pb);
      run_op(OP_RENAME, 4, 4, 5, 0, 0);
      check_value("first freed register", pa, last_dst);
      run_op(OP_FREE, 0, 0, 0, 0, pc);          // Queued behind pb
      run_op(OP_RENAME, 5, 4, 5, 0, 0);
      check_value("second freed register", pb, last_dst);
      run_op(OP_RENAME, 0, 4, 5, 0, 0);
      check_value("third freed register", pc, last_dst);
      while (fl_wr - fl_rd < DEPTH)
         run_op(OP_FREE, 0, 0, 0, 0, rand_bits(PRN_W));
      run_op(OP_FREE, 0, 0, 0, 0, 9);
      check_true(last_fault, "free into a full list was accepted");
      end_test();
   endtask

   task automatic test_checkpoint_ring();
      int start;
      int sel;
      begin_test("checkpoint_ring");
      run_op(OP_RESTORE, 0, 0, 0, rand_bits(CK_W), 0);
      check_true(last_fault, "restore with no live checkpoint was accepted");
      run_op(OP_COMMIT, 0, 0, 0, 0, 0);
      check_true(last_fault, "commit with no live checkpoint was accepted");
      start = ck_tail % NCHECK;
      for (int i = 0; i < NCHECK; i++) begin
         run_op(OP_CHECKPOINT, 0, 0, 0, 0, 0);
         check_value("chk_id sequence", (start + i) % NCHECK, last_chk_id);
      end
      run_op(OP_CHECKPOINT, 0, 0, 0, 0, 0);
      check_true(last_fault, "checkpoint with every slot live was accepted");
      run_op(OP_COMMIT, 0, 0, 0, 0, 0);
      run_op(OP_CHECKPOINT, 0, 0, 0, 0, 0);    // Room again after the commit
      for (int i = 0; i < 3; i++)
         run_op(OP_COMMIT, 0, 0, 0, 0, 0);
      sel = (ck_head + NCHECK - 1) % NCHECK;    // Just behind the oldest live slot
      run_op(OP_RESTORE, 0, 0, 0, sel, 0);
      check_true(last_fault, "restore outside the live range was accepted");
      sel = (ck_head + 2) % NCHECK;
      run_op(OP_RESTORE, 0, 0, 0, sel, 0);
      run_op(OP_RENAME, rand_bits(AR_W), rand_bits(AR_W), rand_bits(AR_W), 0, 0);
      run_op(OP_CHECKPOINT, 0, 0, 0, 0, 0);
      check_value("slot after restore", (sel + 1) % NCHECK, last_chk_id);
      end_test();
   endtask

   // =========================================================================
   // Sequence and report
   // =========================================================================
   initial begin
      op         = OP_NONE;
      areg_dst   = '0;
      areg_src_a = '0;
      areg_src_b = '0;
      chk_sel    = '0;
      free_preg  = '0;
      errors     = 0;
      ops        = 0;
      tests_run  = 0;
      for (int i = 0; i < AREGS; i++)
         model_map[i] = i;                      // Identity map out of reset
      for (int i = 0; i < DEPTH; i++)
         fl_seq[i] = AREGS + i;
      fl_rd   = 0;
      fl_wr   = DEPTH;
      ck_head = 0;
      ck_tail = 0;
      @(negedge reset);
      test_init();
      test_random_renames();
      test_checkpoint_restore();
      test_exhaust_free();
      test_checkpoint_ring();
      $display("%0d tests, %0d ops, %0d errors", tests_run, ops, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   initial begin
      #(LIMIT_NS);
      $display("watchdog: run still going after %0d ns", LIMIT_NS);
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 4,
   parameter int RESET_CYCLES = 5
) (
   output logic clka,
   output logic reset
);
   timeunit 1ns;
   timeprecision 100ps;

   // Reset is held for a whole number of rising edges and released on a
   // falling edge, the same edge the stimulus is driven on
   initial begin
      clka  = 1'b0;
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clka);
      @(negedge clka);
      reset = 1'b0;
   end

   always #(PERIOD_NS / 2) clka = ~clka;    // Free running clock

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the rename stage testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module rename_tb \
   -f sources.f -o rename_sim
./obj_dir/rename_sim | tee sim.log

if grep -qx "test passed" sim.log; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

// ==== source/checkpoint_ram.sv ====
`default_nettype none

module checkpoint_ram #(
   parameter int  AREGS  = rename_pkg::DEF_AREGS,
   parameter int  PREGS  = rename_pkg::DEF_PREGS,
   parameter int  NCHECK = rename_pkg::DEF_NCHECK,
   localparam int ADDR_W = $clog2(NCHECK),
   // Map fields followed by the free list read pointer with its wrap bit
   localparam int WID    = AREGS * $clog2(PREGS) + $clog2(PREGS - AREGS) + 1
) (
   input  logic              clka,
   input  logic              ena,
   input  logic [ADDR_W-1:0] addra,
   input  logic [WID-1:0]    dina,
   input  logic [ADDR_W-1:0] addrb,
   output logic [WID-1:0]    doutb
);

   // Small and wide, so it maps onto distributed RAM
   logic [WID-1:0] mem [NCHECK] = '{default: '0};

   // =========================================================================
   // Port A writes a whole checkpoint on the clock
   // =========================================================================
   always_ff @(posedge clka) begin
      if (ena)
         mem[addra] <= dina;
   end

   // Port B reads without a clock so a restore completes in the same cycle
   assign doutb = mem[addrb];

endmodule

`default_nettype wire

// ==== source/free_list.sv ====
`default_nettype none

module free_list #(
   parameter int  AREGS = rename_pkg::DEF_AREGS,
   parameter int  PREGS = rename_pkg::DEF_PREGS,
   localparam int PRN_W = $clog2(PREGS),
   localparam int DEPTH = PREGS - AREGS,
   localparam int FP_W  = $clog2(DEPTH) + 1,   // Slot index plus a wrap bit
   localparam int CNT_W = $clog2(DEPTH + 1)
) (
   input  logic             clka,
   input  logic             reset,
   input  logic             init_write,
   input  logic             pop,
   input  logic             push,
   input  logic             restore,
   input  logic [PRN_W-1:0] push_preg,
   input  logic [FP_W-1:0]  restore_ptr,
   output logic [PRN_W-1:0] pop_preg,
   output logic [FP_W-1:0]  rd_ptr,
   output logic             empty,
   output logic             full,
   output logic [CNT_W-1:0] count
);

   localparam int IDX_W = FP_W - 1;

   logic [PRN_W-1:0] slots [DEPTH];           // Free physical register numbers
   logic [FP_W-1:0]  wr_ptr;
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;
   logic             wr_en;
   logic [PRN_W-1:0] wr_data;

   // The depth need not be a power of two, so the index wraps by hand and
   // the wrap bit flips each time it does
   function automatic logic [FP_W-1:0] ptr_inc(input logic [FP_W-1:0] p);
      logic [FP_W-1:0] q;
      if (p[IDX_W-1:0] == IDX_W'(DEPTH - 1))
         q = {~p[IDX_W], {IDX_W{1'b0}}};
      else
         q = p + 1'b1;
      return q;
   endfunction

   assign rd_idx = rd_ptr[IDX_W-1:0];
   assign wr_idx = wr_ptr[IDX_W-1:0];

   // =========================================================================
   // Storage
   // =========================================================================
   assign wr_en   = init_write | push;
   // Init hands out every register above the identity map, lowest first
   assign wr_data = init_write ? PRN_W'(AREGS) + PRN_W'(wr_idx) : push_preg;

   always_ff @(posedge clka) begin
      if (wr_en)
         slots[wr_idx] <= wr_data;
   end

   assign pop_preg = slots[rd_idx];            // Head of the list, valid when not empty

   // =========================================================================
   // Pointers
   // =========================================================================
   always_ff @(posedge clka) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
      end else begin
         if (restore)
            rd_ptr <= restore_ptr;             // Registers taken after the branch come back
         else if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         if (wr_en)
            wr_ptr <= ptr_inc(wr_ptr);
      end
   end

   assign empty = (rd_ptr == wr_ptr);
   assign full  = (rd_idx == wr_idx) & (rd_ptr[IDX_W] != wr_ptr[IDX_W]);

   // Occupancy follows from the pointers alone
   always_comb begin
      if (rd_ptr[IDX_W] == wr_ptr[IDX_W])
         count = CNT_W'(wr_idx) - CNT_W'(rd_idx);
      else
         count = CNT_W'(DEPTH) - CNT_W'(rd_idx) + CNT_W'(wr_idx);   // Writer is one lap ahead
   end

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
`default_nettype none

module map_table #(
   parameter int  AREGS = rename_pkg::DEF_AREGS,
   parameter int  PREGS = rename_pkg::DEF_PREGS,
   localparam int AR_W  = $clog2(AREGS),
   localparam int PRN_W = $clog2(PREGS)
) (
   input  logic                   clka,
   input  logic                   reset,
   input  logic                   map_write,
   input  logic                   map_restore,
   input  logic [AR_W-1:0]        areg_dst,
   input  logic [AR_W-1:0]        areg_src_a,
   input  logic [AR_W-1:0]        areg_src_b,
   input  logic [PRN_W-1:0]       new_preg,
   input  logic [AREGS*PRN_W-1:0] restore_word,
   output logic [PRN_W-1:0]       preg_src_a,
   output logic [PRN_W-1:0]       preg_src_b,
   output logic [PRN_W-1:0]       preg_old,
   output logic [AREGS*PRN_W-1:0] map_word
);

   // One physical register number per architectural register
   // Field i sits at bits i*PRN_W, the same layout as the checkpoint word
   logic [AREGS-1:0][PRN_W-1:0] map;

   // =========================================================================
   // Map update
   // =========================================================================
   always_ff @(posedge clka) begin
      if (reset) begin
         // Identity map, register i lives in physical register i
         for (int i = 0; i < AREGS; i++)
            map[i] <= PRN_W'(i);
      end else if (map_restore) begin
         map <= restore_word;                  // Whole map back from a checkpoint
      end else if (map_write) begin
         map[areg_dst] <= new_preg;            // Destination moves to its new register
      end
   end

   // =========================================================================
   // Lookups
   // =========================================================================

   // Reads see the map before this cycle's write, so an instruction that
   // reads its own destination gets the older producer
   assign preg_src_a = map[areg_src_a];
   assign preg_src_b = map[areg_src_b];
   assign preg_old   = map[areg_dst];          // Freed once the instruction retires

   assign map_word = map;                      // Flattened copy for the checkpoint RAM

endmodule

`default_nettype wire

// ==== source/rename_ctrl.sv ====
`default_nettype none

module rename_ctrl #(
   parameter int  AREGS  = rename_pkg::DEF_AREGS,
   parameter int  PREGS  = rename_pkg::DEF_PREGS,
   parameter int  NCHECK = rename_pkg::DEF_NCHECK,
   localparam int CK_W   = $clog2(NCHECK)
) (
   input  logic                   clka,
   input  logic                   reset,
   input  rename_pkg::rename_op_t op,
   input  logic [CK_W-1:0]        chk_sel,
   input  logic                   fl_empty,
   input  logic                   fl_full,
   output logic                   fl_pop,
   output logic                   fl_push,
   output logic                   fl_restore,
   output logic                   map_write,
   output logic                   map_restore,
   output logic                   ckpt_write,
   output logic [CK_W-1:0]        ckpt_waddr,
   output logic                   init_write,
   output logic                   ready,
   output logic                   done,
   output logic                   fault,
   output logic [CK_W-1:0]        chk_id
);
   import rename_pkg::*;

   localparam int FL_DEPTH = PREGS - AREGS;     // Entries loaded during init
   localparam int INIT_W   = $clog2(FL_DEPTH);

   ctrl_state_t       state;
   logic [INIT_W-1:0] init_cnt;                 // Free list slot being filled
   logic [CK_W:0]     ck_head;                  // Oldest live slot, with wrap bit
   logic [CK_W:0]     ck_tail;                  // Next slot to allocate, with wrap bit
   logic [CK_W:0]     ck_live;
   logic [CK_W:0]     ck_tail_rst;
   logic [CK_W-1:0]   ck_ofs;
   logic              ck_empty;
   logic              ck_full;
   logic              ck_in_range;
   logic              ck_commit;
   logic              reject;
   logic              accept;

   assign init_write = (state == ST_INIT);     // One free list entry per init cycle
   assign ready      = (state == ST_READY);
   assign ckpt_waddr = ck_tail[CK_W-1:0];      // New checkpoints go at the tail

   // =========================================================================
   // Checkpoint ring bookkeeping
   // =========================================================================
   always_comb begin
      ck_live     = ck_tail - ck_head;         // Wrap bits make this exact up to NCHECK
      ck_empty    = (ck_live == '0);
      ck_full     = (ck_live == (CK_W + 1)'(NCHECK));
      // Distance of the requested slot from the oldest one
      ck_ofs      = chk_sel - ck_head[CK_W-1:0];
      ck_in_range = ({1'b0, ck_ofs} < ck_live);   // Never true when the ring is empty
      // Restore keeps the chosen slot and drops every younger one
      ck_tail_rst = ck_head + {1'b0, ck_ofs} + 1'b1;
   end

   // =========================================================================
   // Operation check and datapath strobes
   // =========================================================================
   always_comb begin
      unique case (op)
         OP_RENAME:     reject = fl_empty;     // Nothing left to allocate
         OP_CHECKPOINT: reject = ck_full;
         OP_RESTORE:    reject = ~ck_in_range;
         OP_COMMIT:     reject = ck_empty;
         OP_FREE:       reject = fl_full;      // The list cannot hold another entry
         default:       reject = 1'b0;
      endcase
      accept      = ready & ~reject;
      fl_pop      = accept & (op == OP_RENAME);
      map_write   = accept & (op == OP_RENAME);
      ckpt_write  = accept & (op == OP_CHECKPOINT);
      fl_restore  = accept & (op == OP_RESTORE);
      map_restore = accept & (op == OP_RESTORE);
      ck_commit   = accept & (op == OP_COMMIT);
      fl_push     = accept & (op == OP_FREE);
   end

   always_ff @(posedge clka) begin
      if (reset) begin
         state    <= ST_INIT;
         init_cnt <= '0;
         ck_head  <= '0;
         ck_tail  <= '0;
         done     <= 1'b0;
         fault    <= 1'b0;
         chk_id   <= '0;
      end else begin
         if (state == ST_INIT) begin
            init_cnt <= init_cnt + 1'b1;
            // Last slot written on this edge, so serve ops from the next cycle
            if (init_cnt == INIT_W'(FL_DEPTH - 1))
               state <= ST_READY;
         end
         done  <= (op != OP_NONE);             // Every real op is answered one cycle later
         fault <= (op != OP_NONE) & (~ready | reject);
         if (ckpt_write) begin
            ck_tail <= ck_tail + 1'b1;
            chk_id  <= ck_tail[CK_W-1:0];      // Report the slot just taken
         end
         if (map_restore)
            ck_tail <= ck_tail_rst;
         if (ck_commit)
            ck_head <= ck_head + 1'b1;         // Oldest branch resolved
      end
   end

endmodule

`default_nettype wire

// ==== source/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

   // =========================================================================
   // Default sizes of the rename stage
   // =========================================================================

   // Architectural registers seen by the instruction set
   parameter int DEF_AREGS  = 8;
   parameter int DEF_PREGS  = 32;    // Physical registers behind the map
   parameter int DEF_NCHECK = 16;    // Branch checkpoint slots, a power of two

   // =========================================================================
   // Operation codes presented on the op port
   // =========================================================================

   typedef enum logic [2:0] {
      OP_NONE       = 3'd0,          // Idle cycle, no done pulse follows
      OP_RENAME     = 3'd1,          // Look up both sources and allocate a destination
      OP_CHECKPOINT = 3'd2,          // Save the map and the free list read pointer
      OP_RESTORE    = 3'd3,          // Roll back to the slot given on chk_sel
      OP_COMMIT     = 3'd4,          // Release the oldest live checkpoint
      OP_FREE       = 3'd5           // Return a physical register to the free list
   } rename_op_t;

   // =========================================================================
   // Controller states
   // =========================================================================

   // The controller fills the free list first and then serves operations
   typedef enum logic {
      ST_INIT  = 1'b0,
      ST_READY = 1'b1
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/rename_unit.sv ====
`default_nettype none

module rename_unit #(
   parameter int  AREGS  = rename_pkg::DEF_AREGS,
   parameter int  PREGS  = rename_pkg::DEF_PREGS,
   parameter int  NCHECK = rename_pkg::DEF_NCHECK,
   localparam int AR_W   = $clog2(AREGS),
   localparam int PRN_W  = $clog2(PREGS),
   localparam int CK_W   = $clog2(NCHECK),
   localparam int CNT_W  = $clog2(PREGS - AREGS + 1)
) (
   input  logic                   clka,
   input  logic                   reset,
   input  rename_pkg::rename_op_t op,
   input  logic [AR_W-1:0]        areg_dst,
   input  logic [AR_W-1:0]        areg_src_a,
   input  logic [AR_W-1:0]        areg_src_b,
   input  logic [CK_W-1:0]        chk_sel,
   input  logic [PRN_W-1:0]       free_preg,
   output logic                   ready,
   output logic                   done,
   output logic                   fault,
   output logic [PRN_W-1:0]       preg_src_a,
   output logic [PRN_W-1:0]       preg_src_b,
   output logic [PRN_W-1:0]       preg_dst,
   output logic [PRN_W-1:0]       preg_old,
   output logic [CK_W-1:0]        chk_id,
   output logic [CNT_W-1:0]       free_count
);

   localparam int FP_W  = $clog2(PREGS - AREGS) + 1;
   localparam int MAP_W = AREGS * PRN_W;

   logic              fl_pop;
   logic              fl_push;
   logic              fl_restore;
   logic              fl_empty;
   logic              fl_full;
   logic              map_write;
   logic              map_restore;
   logic              ckpt_write;
   logic [CK_W-1:0]   ckpt_waddr;
   logic              init_write;
   logic [PRN_W-1:0]  fl_pop_preg;
   logic [FP_W-1:0]   fl_rd_ptr;
   logic [MAP_W-1:0]  map_word;
   logic [MAP_W+FP_W-1:0] ck_rdata;
   logic [PRN_W-1:0]  lk_src_a;
   logic [PRN_W-1:0]  lk_src_b;
   logic [PRN_W-1:0]  lk_old;

   rename_ctrl #(.AREGS(AREGS), .PREGS(PREGS), .NCHECK(NCHECK)) u_ctrl (
      .clka        (clka),
      .reset       (reset),
      .op          (op),
      .chk_sel     (chk_sel),
      .fl_empty    (fl_empty),
      .fl_full     (fl_full),
      .fl_pop      (fl_pop),
      .fl_push     (fl_push),
      .fl_restore  (fl_restore),
      .map_write   (map_write),
      .map_restore (map_restore),
      .ckpt_write  (ckpt_write),
      .ckpt_waddr  (ckpt_waddr),
      .init_write  (init_write),
      .ready       (ready),
      .done        (done),
      .fault       (fault),
      .chk_id      (chk_id)
   );

   // The new destination is the head of the free list
   map_table #(.AREGS(AREGS), .PREGS(PREGS)) u_map (
      .clka         (clka),
      .reset        (reset),
      .map_write    (map_write),
      .map_restore  (map_restore),
      .areg_dst     (areg_dst),
      .areg_src_a   (areg_src_a),
      .areg_src_b   (areg_src_b),
      .new_preg     (fl_pop_preg),
      .restore_word (ck_rdata[MAP_W+FP_W-1:FP_W]),
      .preg_src_a   (lk_src_a),
      .preg_src_b   (lk_src_b),
      .preg_old     (lk_old),
      .map_word     (map_word)
   );

   // Checkpoint word is the map on top and the read pointer below it
   checkpoint_ram #(.AREGS(AREGS), .PREGS(PREGS), .NCHECK(NCHECK)) u_ckpt (
      .clka  (clka),
      .ena   (ckpt_write),
      .addra (ckpt_waddr),
      .dina  ({map_word, fl_rd_ptr}),
      .addrb (chk_sel),
      .doutb (ck_rdata)
   );

   free_list #(.AREGS(AREGS), .PREGS(PREGS)) u_free (
      .clka        (clka),
      .reset       (reset),
      .init_write  (init_write),
      .pop         (fl_pop),
      .push        (fl_push),
      .restore     (fl_restore),
      .push_preg   (free_preg),
      .restore_ptr (ck_rdata[FP_W-1:0]),
      .pop_preg    (fl_pop_preg),
      .rd_ptr      (fl_rd_ptr),
      .empty       (fl_empty),
      .full        (fl_full),
      .count       (free_count)
   );

   // Results line up with done, one cycle after the op is presented
   always_ff @(posedge clka) begin
      preg_src_a <= lk_src_a;
      preg_src_b <= lk_src_b;
      preg_dst   <= fl_pop_preg;
      preg_old   <= lk_old;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
source/rename_pkg.sv
source/rename_ctrl.sv
source/map_table.sv
source/checkpoint_ram.sv
source/free_list.sv
source/rename_unit.sv
bench/tb_clock.sv
bench/rename_chk.sv
bench/rename_tb.sv
